// File: risc14.f
verilog/riscPkg.sv
verilog/aluUnit.sv
verilog/regFile.sv
verilog/fetchUnit.sv
verilog/operandStage.sv
verilog/executeStage.sv
verilog/wbMaster.sv
verilog/riscCpu.sv
tb/tbMemory.sv
tb/risc14Tb.sv

// File: run.sh
#!/bin/sh
# Build and run the risc14 testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module risc14Tb -f risc14.f -o risc14Sim \
	&& ./obj_dir/risc14Sim > sim.log 2>&1 ; cat sim.log \
	&& grep -q "^Testbench passed$" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }

// File: tb/risc14Tb.sv
`timescale 1ns/10ps

module risc14Tb import riscPkg::*; ();
	localparam int dataBase = 'h200;
	localparam int eventTimeout = 3000;	// Cycles between two events

	logic Clock_not;
	logic reset;
	logic [4:0] switches;
	logic [7:0] display;
	logic displayStrobe;
	wbReq_t busReq;
	wbRsp_t busRsp;

	logic [wordWidth-1:0] modelMem [1024];
	logic [wordWidth-1:0] modelRegs [16];
	logic mC, mN, mV, mZ;	// Model flags
	logic [4:0] switchValue;
	int expKind[$];	// 0 for OUT, 1 for a store
	int expAdr[$];
	int expVal[$];
	int ptr;
	int eventCount;
	int eventIndex;
	logic resetDone;
	integer seed;

	riscCpu i_dut (.Clock_not(Clock_not), .reset(reset), .switches(switches),
		.display(display), .displayStrobe(displayStrobe), .busReq(busReq), .busRsp(busRsp));

	tbMemory i_mem (.Clock_not(Clock_not), .reset(reset), .busReq(busReq), .busRsp(busRsp));

	initial begin
		Clock_not = 1'b0;
		forever #20 Clock_not = ~Clock_not;
	end

	task automatic checkValue(input string name, input int expected, input int actual);
		assert (expected == actual) else begin
			$display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	task automatic reportFailure(input string what);
		$display("%s", what);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic writeWord(input int adr, input logic [wordWidth-1:0] w);
		i_mem.mem[adr] = w;
		modelMem[adr] = w;
	endtask

	function automatic logic [wordWidth-1:0] instrWord(input opcode_e op, input int ri,
		input int rj);
		return {op, 4'(ri), 4'(rj)};
	endfunction

	task automatic emit(input opcode_e op, input int ri, input int rj);
		writeWord(ptr, instrWord(op, ri, rj));
		ptr++;
	endtask

	task automatic emitTwo(input opcode_e op, input int ri, input int rj, input int ext);
		emit(op, ri, rj);
		writeWord(ptr, 14'(ext));
		ptr++;
	endtask

	// Taken jump skips the OUT of the marker R5
	task automatic condBlock();
		jumpCond_e conds[9] = '{condJu, condJc1, condJn1, condJv1, condJz1,
			condJc0, condJn0, condJv0, condJz0};
		foreach (conds[i]) begin
			emitTwo(opcJmp, 0, conds[i], ptr + 3);
			emit(opcOut, 5, 0);
		end
	endtask

	task automatic buildProgram();
		opcode_e logicOps[4] = '{opcNot, opcAnd, opcOr, opcXor};
		opcode_e shiftOps[4] = '{opcSrl, opcSra, opcRotl, opcRotr};
		int loopAdr;
		ptr = 0;
		emitTwo(opcLd, 0, 1, dataBase);
		emitTwo(opcLd, 0, 2, dataBase + 1);
		emit(opcAddc, 5, 7);
		emit(opcCpy, 3, 1);
		emit(opcAdd, 3, 2);
		emit(opcOut, 3, 0);
		condBlock();
		emit(opcCpy, 4, 1);
		emit(opcSub, 4, 2);
		emit(opcOut, 4, 0);
		condBlock();
		emit(opcSub, 6, 6);	// Zero result
		condBlock();
		emit(opcAddc, 4, 5);
		emit(opcOut, 4, 0);
		emit(opcSubc, 4, 9);
		emit(opcOut, 4, 0);
		condBlock();
		foreach (logicOps[i]) begin
			emit(opcCpy, 7, 1);
			emit(logicOps[i], 7, 2);
			emit(opcOut, 7, 0);
			emitTwo(opcSt, 0, 7, 'h210 + i);
		end
		for (int n = 0; n < 16; n++) begin
			emit(opcCpy, 8, 1);
			emit(shiftOps[n / 4], 8, n % 4);
			emit(opcOut, 8, 0);
			emitTwo(opcSt, 0, 8, 'h220 + n);
		end
		emit(opcAdd, 3, 3);	// Forwarding chain
		emit(opcAdd, 3, 1);
		emit(opcXor, 3, 2);
		emit(opcSubc, 3, 1);
		emit(opcOut, 3, 0);
		emitTwo(opcSt, 0, 3, 'h240);
		emit(opcIn, 9, 0);
		emit(opcCpy, 11, 9);
		emitTwo(opcSt, 11, 1, 'h260);
		emitTwo(opcLd, 11, 12, 'h260);
		emit(opcAdd, 12, 2);
		emit(opcOut, 12, 0);
		emitTwo(opcSt, 11, 12, 'h280);
		emitTwo(opcLd, 11, 13, dataBase);
		emit(opcOut, 13, 0);
		emitTwo(opcSt, 0, 13, 'h2a0);
		loopAdr = ptr;
		emit(opcOut, 9, 0);	// Count down the switches value
		emit(opcSubc, 9, 1);
		emitTwo(opcJmp, 0, condJz0, loopAdr);
		emitTwo(opcJmp, 0, condJu, ptr);
	endtask

	function automatic logic jumpTaken(input logic [3:0] cond);
		case (cond)
			4'b0000: return 1'b1;
			4'b1000: return mC;
			4'b0100: return mN;
			4'b0010: return mV;
			4'b0001: return mZ;
			4'b0111: return !mC;
			4'b1011: return !mN;
			4'b1101: return !mV;
			4'b1110: return !mZ;
			default: return 1'b0;
		endcase
	endfunction

	// Two's complement value of a word
	function automatic int signedValue(input logic [13:0] v);
		return v[13] ? int'(v) - 16384 : int'(v);
	endfunction

	// Reference interpreter that fills the expected event queues
	function automatic int runModel();
		logic [13:0] pc, w, ea, a, b, res;
		logic [3:0] ri, rj;
		logic [1:0] amt;
		logic setNz, writeRi;
		opcode_e op;
		pc = 0;
		for (int steps = 0; steps < 20000; steps++) begin
			w = modelMem[pc[9:0]];
			op = opcode_e'(w[13:8]);
			ri = w[7:4];
			rj = w[3:0];
			amt = rj[1:0];
			pc = pc + 14'd1;
			ea = '0;
			if (op == opcLd || op == opcSt || op == opcJmp) begin
				ea = modelMem[pc[9:0]] + ((ri == 0) ? 14'd0 : modelRegs[ri]);
				pc = pc + 14'd1;
			end
			a = modelRegs[ri];
			b = (op == opcAddc || op == opcSubc) ? 14'(rj) : modelRegs[rj];
			res = a;
			setNz = 1'b1;
			writeRi = 1'b1;
			case (op)
				opcAdd, opcAddc: begin
					res = a + b;
					mC = (int'(a) + int'(b)) > 16383;
					mV = (signedValue(a) + signedValue(b)) != signedValue(res);
				end
				opcSub, opcSubc: begin
					res = a - b;
					mC = (a < b);	// Borrow
					mV = (signedValue(a) - signedValue(b)) != signedValue(res);
				end
				opcNot: res = ~a;
				opcAnd: res = a & b;
				opcOr: res = a | b;
				opcXor: res = a ^ b;
				default: setNz = 1'b0;
			endcase
			case (op)
				opcSrl: res = a >> amt;
				opcSra: res = (a >> amt) | ({14{a[13]}} << (14 - amt));	// Sign bits on top
				opcRotl: res = (a << amt) | (a >> (14 - amt));
				opcRotr: res = (a >> amt) | (a << (14 - amt));
				opcCpy: res = modelRegs[rj];
				opcIn: res = 14'(switchValue);
				default: writeRi = setNz;
			endcase
			if (setNz) begin
				mN = res[13];
				mZ = (res == 0);
			end
			if (writeRi)
				modelRegs[ri] = res;
			if (op == opcLd)
				modelRegs[rj] = modelMem[ea[9:0]];
			if (op == opcSt) begin
				modelMem[ea[9:0]] = modelRegs[rj];
				expKind.push_back(1);
				expAdr.push_back(int'(ea));
				expVal.push_back(int'(modelRegs[rj]));
			end
			if (op == opcOut) begin
				expKind.push_back(0);
				expAdr.push_back(0);
				expVal.push_back(int'(a[7:0]));
			end
			if (op == opcJmp && jumpTaken(rj)) begin
				if (ea == pc - 14'd2)
					return expKind.size();	// Jump to itself ends the program
				pc = ea;
			end
		end
		return -1;
	endfunction

	task automatic matchEvent(input int kind, input int adr, input int value);
		string name;
		int expectedAdr;
		name = $sformatf("event %0d", eventIndex);
		assert (expKind.size() > 0) else
			reportFailure($sformatf("%s is an OUT or store after all expected events", name));
		checkValue({name, " kind"}, expKind.pop_front(), kind);
		expectedAdr = expAdr.pop_front();
		if (kind == 1)
			checkValue({name, " store address"}, expectedAdr, adr);
		checkValue({name, " value"}, expVal.pop_front(), value);
		eventIndex++;
	endtask

	initial begin
		reset = 1'b1;
		resetDone = 1'b0;
		eventIndex = 0;
		seed = 78;
		switchValue = 5'(($random(seed) & 15) + 16);	// Never zero
		switches = switchValue;
		for (int i = 0; i < 16; i++)
			modelRegs[i] = '0;
		{mC, mN, mV, mZ} = 4'b0;
		for (int i = 0; i < 1024; i++)
			writeWord(i, 14'(i * 97 + 'h155));
		for (int i = 0; i < 32; i++)
			writeWord(dataBase + i, 14'($random(seed)));
		buildProgram();
		eventCount = runModel();
		assert (eventCount > 0) else
			reportFailure("Reference model never reached the final jump");
		repeat (4) @(posedge Clock_not);
		@(negedge Clock_not);
		checkValue("reset cyc", 0, busReq.cyc);
		checkValue("reset stb", 0, busReq.stb);
		checkValue("reset displayStrobe", 0, displayStrobe);
		checkValue("reset display", 0, display);
		reset = 1'b0;
		resetDone = 1'b1;
	end

	// Compare process
	initial begin
		int idle;
		idle = 0;
		while (!resetDone) begin
			@(negedge Clock_not);
			idle++;
			if (idle > 20)
				reportFailure("Timeout: reset was never released");
		end
		idle = 0;
		while (!busReq.cyc) begin
			@(negedge Clock_not);
			idle++;
			if (idle > 20)
				reportFailure("Timeout: no bus cycle started after reset");
		end
		checkValue("first transfer address", 0, busReq.adr);
		checkValue("first transfer write enable", 0, busReq.we);
		idle = 0;
		while (expKind.size() > 0) begin
			@(negedge Clock_not);
			idle++;
			if (displayStrobe) begin
				matchEvent(0, 0, int'(display));
				idle = 0;
			end
			if (busReq.cyc && busReq.we && busRsp.ack) begin
				matchEvent(1, int'(busReq.adr), int'(busReq.datOut));
				idle = 0;
			end
			if (idle > eventTimeout)
				reportFailure($sformatf("Timeout: no OUT or store came after event %0d",
					eventIndex));
		end
		$display("Testbench passed");
		$finish;
	end

endmodule

// File: tb/tbMemory.sv
`timescale 1ns/10ps

module tbMemory import riscPkg::*; (
	input logic Clock_not,
	input logic reset,
	input wbReq_t busReq,
	output wbRsp_t busRsp
);
	logic [wordWidth-1:0] mem [1024];	// Code and data
	logic [1:0] waitCount;
	integer seed;

	initial begin
		seed = 78;
		busRsp = '0;
	end

	always @(posedge Clock_not) begin
		if (reset) begin
			busRsp.ack <= 1'b0;
			busRsp.datIn <= '0;
			waitCount <= 2'd0;
		end else begin
			busRsp.ack <= 1'b0;	// Ack lasts one cycle
			if (busReq.cyc && busReq.stb && !busRsp.ack) begin
				if (waitCount == 2'd0) begin
					busRsp.ack <= 1'b1;
					busRsp.datIn <= mem[busReq.adr[9:0]];
					if (busReq.we)
						mem[busReq.adr[9:0]] <= busReq.datOut;
					waitCount <= 2'($random(seed));	// Waits for the next transfer
				end else begin
					waitCount <= waitCount - 2'd1;
				end
			end
		end
	end

endmodule

// File: verilog/riscCpu.sv
`timescale 1ns/10ps

module riscCpu import riscPkg::*; (
	input logic Clock_not,
	input logic reset,
	input logic [4:0] switches,
	output logic [7:0] display,
	output logic displayStrobe,
	output wbReq_t busReq,
	input wbRsp_t busRsp
);
	fetchPacket_t fetchPkt;
	operandPacket_t opPkt;
	writePacket_t writePkt;	// Register write and forwarding path
	busCmd_t fetchCmd;
	busCmd_t dataCmd;
	redirect_t redirect;
	logic resume;
	logic fetchDone;
	logic dataDone;
	logic [wordWidth-1:0] readData;
	logic [wordWidth-1:0] readA;
	logic [wordWidth-1:0] readB;
	logic [3:0] readIdxA;
	logic [3:0] readIdxB;

	fetchUnit i_fetch (.Clock_not(Clock_not), .reset(reset), .fetchCmd(fetchCmd),
		.fetchDone(fetchDone), .fetchData(readData), .redirect(redirect),
		.resume(resume), .fetchOut(fetchPkt));

	operandStage i_operand (.Clock_not(Clock_not), .reset(reset), .fetchIn(fetchPkt),
		.readIdxA(readIdxA), .readIdxB(readIdxB), .readA(readA), .readB(readB),
		.forwardIn(writePkt), .opOut(opPkt));

	executeStage i_execute (.Clock_not(Clock_not), .reset(reset), .opIn(opPkt),
		.switches(switches), .dataCmd(dataCmd), .dataDone(dataDone), .dataIn(readData),
		.writeOut(writePkt), .redirect(redirect), .resume(resume), .display(display),
		.displayStrobe(displayStrobe));

	regFile i_regs (.Clock_not(Clock_not), .reset(reset), .readIdxA(readIdxA),
		.readIdxB(readIdxB), .readA(readA), .readB(readB), .writeIn(writePkt));

	wbMaster i_bus (.Clock_not(Clock_not), .reset(reset), .fetchCmd(fetchCmd),
		.dataCmd(dataCmd), .fetchDone(fetchDone), .dataDone(dataDone),
		.readData(readData), .busReq(busReq), .busRsp(busRsp));

endmodule

// File: verilog/wbMaster.sv
`timescale 1ns/10ps

module wbMaster import riscPkg::*; (
	input logic Clock_not,
	input logic reset,
	input busCmd_t fetchCmd,
	input busCmd_t dataCmd,
	output logic fetchDone,
	output logic dataDone,
	output logic [wordWidth-1:0] readData,
	output wbReq_t busReq,
	input wbRsp_t busRsp
);
	typedef enum logic {
		busIdle,
		busActive
	} busState_e;

	busState_e state;
	logic ownerData;	// Data side holds the open cycle
	busCmd_t pick;

	assign pick = dataCmd.valid ? dataCmd : fetchCmd;	// Data before fetch

	assign fetchDone = (state == busActive) && busRsp.ack && !ownerData;
	assign dataDone = (state == busActive) && busRsp.ack && ownerData;
	assign readData = busRsp.datIn;

	always_ff @(posedge Clock_not) begin
		if (reset) begin
			state <= busIdle;
			ownerData <= 1'b0;
			busReq.cyc <= 1'b0;
			busReq.stb <= 1'b0;
			busReq.we <= 1'b0;
		end else if (state == busIdle) begin
			if (pick.valid) begin
				state <= busActive;
				ownerData <= dataCmd.valid;
				busReq.cyc <= 1'b1;
				busReq.stb <= 1'b1;
				busReq.we <= pick.we;
				busReq.adr <= pick.adr;
				busReq.datOut <= pick.wdat;
			end
		end else if (busRsp.ack) begin
			state <= busIdle;	// One idle cycle before the next transfer
			busReq.cyc <= 1'b0;
			busReq.stb <= 1'b0;
			busReq.we <= 1'b0;
		end
	end

endmodule

// File: verilog/executeStage.sv
`timescale 1ns/10ps

module executeStage import riscPkg::*; (
	input logic Clock_not,
	input logic reset,
	input operandPacket_t opIn,
	input logic [4:0] switches,
	output busCmd_t dataCmd,
	input logic dataDone,
	input logic [wordWidth-1:0] dataIn,
	output writePacket_t writeOut,
	output redirect_t redirect,
	output logic resume,
	output logic [7:0] display,
	output logic displayStrobe
);
	flags_t flags;
	flags_t aluFlags;
	logic [wordWidth-1:0] aluResult;
	logic [wordWidth-1:0] effAddr;
	logic [3:0] loadIdx;	// Destination of the open LD
	logic condMet;
	logic isJump;

	aluUnit i_alu (.opcode(opIn.opcode), .a(opIn.a), .b(opIn.b), .amount(opIn.rj[1:0]),
		.flagsIn(flags), .result(aluResult), .flagsOut(aluFlags));

	assign effAddr = opIn.base + opIn.a;
	assign isJump = opIn.valid && (opIn.opcode == opcJmp);

	always_comb begin
		case (jumpCond_e'(opIn.rj))
			condJu: condMet = 1'b1;
			condJc1: condMet = flags.carry;
			condJn1: condMet = flags.negative;
			condJv1: condMet = flags.overflow;
			condJz1: condMet = flags.zero;
			condJc0: condMet = !flags.carry;
			condJn0: condMet = !flags.negative;
			condJv0: condMet = !flags.overflow;
			condJz0: condMet = !flags.zero;
			default: condMet = 1'b0;
		endcase
	end

	assign redirect.valid = isJump && condMet;
	assign redirect.target = effAddr;
	assign resume = (dataCmd.valid && dataDone) || isJump;	// Releases the held fetch

	always_comb begin
		writeOut.valid = 1'b0;
		writeOut.idx = opIn.ri;
		writeOut.value = aluResult;
		if (dataCmd.valid && !dataCmd.we && dataDone) begin
			writeOut.valid = 1'b1;
			writeOut.idx = loadIdx;
			writeOut.value = dataIn;
		end else if (opIn.valid) begin
			if (opIn.opcode inside {opcCpy, opcAdd, opcSub, opcAddc, opcSubc, opcNot, opcAnd,
				opcOr, opcXor, opcSrl, opcSra, opcRotl, opcRotr})
				writeOut.valid = 1'b1;
			if (opIn.opcode == opcIn) begin
				writeOut.valid = 1'b1;
				writeOut.value = {{(wordWidth-5){1'b0}}, switches};
			end
		end
	end

	always_ff @(posedge Clock_not) begin
		if (reset) begin
			dataCmd.valid <= 1'b0;
			dataCmd.we <= 1'b0;
			flags <= '0;
			display <= '0;
			displayStrobe <= 1'b0;
		end else begin
			displayStrobe <= 1'b0;
			if (dataDone)
				dataCmd.valid <= 1'b0;
			if (opIn.valid) begin
				flags <= aluFlags;	// Unchanged for non-ALU ops
				case (opIn.opcode)
					opcLd, opcSt: begin
						dataCmd.valid <= 1'b1;
						dataCmd.we <= (opIn.opcode == opcSt);
						dataCmd.adr <= effAddr;
						dataCmd.wdat <= opIn.b;	// R[Rj] for ST
						loadIdx <= opIn.rj;
					end
					opcOut: begin
						display <= opIn.a[7:0];
						displayStrobe <= 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

endmodule

// File: verilog/operandStage.sv
`timescale 1ns/10ps

module operandStage import riscPkg::*; (
	input logic Clock_not,
	input logic reset,
	input fetchPacket_t fetchIn,
	output logic [3:0] readIdxA,
	output logic [3:0] readIdxB,
	input logic [wordWidth-1:0] readA,
	input logic [wordWidth-1:0] readB,
	input writePacket_t forwardIn,
	output operandPacket_t opOut
);
	logic [wordWidth-1:0] instr;
	logic [wordWidth-1:0] valA;
	logic [wordWidth-1:0] valB;
	opcode_e opcode;

	assign instr = fetchIn.valid ? fetchIn.instr : nopWord;	// Bubble decodes as NOP
	assign opcode = opcode_e'(instr[13:8]);
	assign readIdxA = instr[7:4];
	assign readIdxB = instr[3:0];

	always_comb begin
		valA = (forwardIn.valid && forwardIn.idx == readIdxA) ? forwardIn.value : readA;
		valB = (forwardIn.valid && forwardIn.idx == readIdxB) ? forwardIn.value : readB;
		// R0 as memory index means no index
		if (opcode inside {opcLd, opcSt, opcJmp} && readIdxA == 4'd0)
			valA = '0;
		if (opcode inside {opcAddc, opcSubc})
			valB = {{(wordWidth-4){1'b0}}, readIdxB};	// Constant from Rj field
	end

	always_ff @(posedge Clock_not) begin
		if (reset)
			opOut.valid <= 1'b0;
		else
			opOut.valid <= fetchIn.valid;
		opOut.opcode <= opcode;
		opOut.ri <= readIdxA;
		opOut.rj <= readIdxB;
		opOut.a <= valA;
		opOut.b <= valB;
		opOut.base <= fetchIn.ext;
	end

endmodule

// File: verilog/fetchUnit.sv
`timescale 1ns/10ps

module fetchUnit import riscPkg::*; (
	input logic Clock_not,
	input logic reset,
	output busCmd_t fetchCmd,
	input logic fetchDone,
	input logic [wordWidth-1:0] fetchData,
	input redirect_t redirect,
	input logic resume,
	output fetchPacket_t fetchOut
);
	typedef enum logic [1:0] {
		stInstr,
		stExt,
		stHeld
	} fetchState_e;

	fetchState_e state;
	logic [wordWidth-1:0] pc;
	logic [wordWidth-1:0] instrWord;	// First word of a two-word instruction
	logic twoWord;

	assign twoWord = opcode_e'(fetchData[13:8]) inside {opcLd, opcSt, opcJmp};

	// Reads only, from the program counter
	assign fetchCmd.valid = (state != stHeld);
	assign fetchCmd.we = 1'b0;
	assign fetchCmd.adr = pc;
	assign fetchCmd.wdat = '0;

	always_ff @(posedge Clock_not) begin
		if (reset) begin
			state <= stInstr;
			pc <= resetPc;
			fetchOut.valid <= 1'b0;
		end else begin
			fetchOut.valid <= 1'b0;	// Valid for one cycle per instruction
			case (state)
				stInstr: begin
					if (fetchDone) begin
						pc <= pc + 1'b1;
						if (twoWord) begin
							instrWord <= fetchData;
							state <= stExt;
						end else begin
							fetchOut.valid <= 1'b1;
							fetchOut.instr <= fetchData;
							fetchOut.ext <= '0;
						end
					end
				end
				stExt: begin
					if (fetchDone) begin
						pc <= pc + 1'b1;
						fetchOut.valid <= 1'b1;
						fetchOut.instr <= instrWord;
						fetchOut.ext <= fetchData;
						state <= stHeld;
					end
				end
				stHeld: begin
					// Wait for the memory access or jump decision
					if (resume) begin
						state <= stInstr;
						if (redirect.valid)
							pc <= redirect.target;	// Taken jump
					end
				end
				default: state <= stInstr;
			endcase
		end
	end

endmodule

// File: verilog/regFile.sv
`timescale 1ns/10ps

module regFile import riscPkg::*; (
	input logic Clock_not,
	input logic reset,
	input logic [3:0] readIdxA,
	input logic [3:0] readIdxB,
	output logic [wordWidth-1:0] readA,
	output logic [wordWidth-1:0] readB,
	input writePacket_t writeIn
);
	logic [wordWidth-1:0] regs [regCount];

	// New value wins over the stored one
	assign readA = (writeIn.valid && writeIn.idx == readIdxA) ? writeIn.value
		: regs[readIdxA];
	assign readB = (writeIn.valid && writeIn.idx == readIdxB) ? writeIn.value
		: regs[readIdxB];

	always_ff @(posedge Clock_not) begin
		if (reset) begin
			for (int i = 0; i < regCount; i++)
				regs[i] <= '0;
		end else if (writeIn.valid) begin
			regs[writeIn.idx] <= writeIn.value;
		end
	end

endmodule

// File: verilog/aluUnit.sv
`timescale 1ns/10ps

module aluUnit import riscPkg::*; (
	input opcode_e opcode,
	input logic [wordWidth-1:0] a,
	input logic [wordWidth-1:0] b,
	input logic [1:0] amount,
	input flags_t flagsIn,
	output logic [wordWidth-1:0] result,
	output flags_t flagsOut
);
	logic [wordWidth:0] sum;
	logic [wordWidth:0] diff;
	logic [2*wordWidth-1:0] rotL;
	logic [2*wordWidth-1:0] rotR;

	assign sum = {1'b0, a} + {1'b0, b};
	assign diff = {1'b0, a} - {1'b0, b};	// Top bit is the borrow
	assign rotL = {a, a} << amount;
	assign rotR = {a, a} >> amount;

	always_comb begin
		result = a;
		flagsOut = flagsIn;
		case (opcode)
			opcAdd, opcAddc: begin
				result = sum[wordWidth-1:0];
				flagsOut.carry = sum[wordWidth];
				// Same signs in, other sign out
				flagsOut.overflow = (a[wordWidth-1] == b[wordWidth-1])
					&& (result[wordWidth-1] != a[wordWidth-1]);
			end
			opcSub, opcSubc: begin
				result = diff[wordWidth-1:0];
				flagsOut.carry = diff[wordWidth];
				flagsOut.overflow = (a[wordWidth-1] != b[wordWidth-1])
					&& (result[wordWidth-1] != a[wordWidth-1]);
			end
			opcNot: begin
				result = ~a;
			end
			opcAnd: begin
				result = a & b;
			end
			opcOr: begin
				result = a | b;
			end
			opcXor: begin
				result = a ^ b;
			end
			opcSrl: begin
				result = a >> amount;
			end
			opcSra: begin
				result = $signed(a) >>> amount;	// Sign fill
			end
			opcRotl: begin
				result = rotL[2*wordWidth-1:wordWidth];
			end
			opcRotr: begin
				result = rotR[wordWidth-1:0];
			end
			opcCpy: begin
				result = b;
			end
			default: ;
		endcase
		// N and Z follow arithmetic and logic results only
		if (opcode inside {opcAdd, opcAddc, opcSub, opcSubc, opcNot, opcAnd, opcOr, opcXor}) begin
			flagsOut.negative = result[wordWidth-1];
			flagsOut.zero = (result == '0);
		end
	end

endmodule

// File: verilog/riscPkg.sv
package riscPkg;

	localparam int wordWidth = 14;
	localparam int regCount = 16;
	localparam logic [wordWidth-1:0] nopWord = '1;	// Empty stage marker
	localparam logic [wordWidth-1:0] resetPc = '0;

	typedef enum logic [5:0] {
		opcLd   = 6'd0,
		opcSt   = 6'd1,
		opcCpy  = 6'd2,
		opcJmp  = 6'd4,
		opcAdd  = 6'd5,
		opcSub  = 6'd6,
		opcAddc = 6'd7,	// Add the Rj field as a constant
		opcSubc = 6'd8,
		opcNot  = 6'd11,
		opcAnd  = 6'd12,
		opcOr   = 6'd13,
		opcXor  = 6'd14,
		opcSrl  = 6'd15,
		opcSra  = 6'd16,
		opcRotl = 6'd17,
		opcRotr = 6'd18,
		opcIn   = 6'd27,
		opcOut  = 6'd28,
		opcNop  = 6'd29
	} opcode_e;

	typedef enum logic [3:0] {
		condJu  = 4'b0000,
		condJc1 = 4'b1000,
		condJn1 = 4'b0100,
		condJv1 = 4'b0010,
		condJz1 = 4'b0001,
		condJc0 = 4'b0111,
		condJn0 = 4'b1011,
		condJv0 = 4'b1101,
		condJz0 = 4'b1110
	} jumpCond_e;

	typedef struct packed {
		logic carry;
		logic negative;
		logic overflow;
		logic zero;
	} flags_t;

	typedef struct packed {
		logic valid;
		logic [wordWidth-1:0] instr;
		logic [wordWidth-1:0] ext;	// Base word of LD, ST and JMP
	} fetchPacket_t;

	typedef struct packed {
		logic valid;
		opcode_e opcode;
		logic [3:0] ri;
		logic [3:0] rj;
		logic [wordWidth-1:0] a;
		logic [wordWidth-1:0] b;
		logic [wordWidth-1:0] base;
	} operandPacket_t;

	typedef struct packed {
		logic valid;
		logic [3:0] idx;
		logic [wordWidth-1:0] value;
	} writePacket_t;

	typedef struct packed {
		logic valid;
		logic we;
		logic [wordWidth-1:0] adr;
		logic [wordWidth-1:0] wdat;
	} busCmd_t;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [wordWidth-1:0] adr;
		logic [wordWidth-1:0] datOut;
	} wbReq_t;

	typedef struct packed {
		logic ack;
		logic [wordWidth-1:0] datIn;
	} wbRsp_t;

	typedef struct packed {
		logic valid;
		logic [wordWidth-1:0] target;
	} redirect_t;

endpackage
